// ==== tetris_grid_pkg.sv ====
package tetris_grid_pkg;

    // Board geometry
    localparam int ROWS = 22;
    localparam int COLS = 10;

    // One row of cells, bit 0 is the leftmost column
    typedef logic [COLS-1:0] row_t;

    // Whole board, row 0 at the top
    typedef row_t [0:ROWS-1] grid_t;

    typedef logic [4:0] row_idx_t;      // Enough for 22 rows
    typedef logic [15:0] score_t;       // Cleared line count

    // Frame handed to the renderer
    typedef struct packed {
        grid_t  cells;                  // Stored board with piece on top
        score_t score;
        logic   game_over;
    } frame_t;

endpackage

// ==== tetris_piece_pkg.sv ====
package tetris_piece_pkg;

    // Game FSM states
    typedef enum logic [2:0] {
        SPAWN,
        FALLING,
        LOCK,
        CLEAR,
        OVER
    } game_state_t;

    // Shape index, order I O T S Z J L
    typedef logic [2:0] piece_t;

    localparam int NUM_PIECES = 7;

    // Spawn window on the board
    localparam int MASK_ROWS = 2;       // Rows 0 and 1
    localparam int MASK_COLS = 4;       // Columns 3 to 6
    localparam int SPAWN_COL = 3;       // Leftmost column of the window

    // Bit 0 of a mask row lands in SPAWN_COL
    typedef logic [MASK_COLS-1:0] mask_row_t;
    typedef mask_row_t [0:MASK_ROWS-1] mask_t;

    // Per shape, element 0 is board row 0
    localparam mask_t SPAWN_MASK [NUM_PIECES] = '{
        '{4'b0000, 4'b1111},            // I
        '{4'b0110, 4'b0110},            // O
        '{4'b0111, 4'b0010},            // T
        '{4'b0110, 4'b0011},            // S
        '{4'b0011, 4'b0110},            // Z
        '{4'b0001, 4'b0111},            // J
        '{4'b0100, 4'b0111}             // L
    };

endpackage

// ==== piece_generator.sv ====
`timescale 1ns/100ps

module piece_generator
    import tetris_grid_pkg::*;
    import tetris_piece_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  advance,              // One pulse per locked piece
    output grid_t spawn_grid            // Current shape at spawn spot
);

    piece_t idx_q;                      // Current shape

    // Fixed repeating order, wraps after L
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            idx_q <= '0;                // Start with I
        end else if (advance) begin
            if (idx_q == piece_t'(NUM_PIECES - 1))
                idx_q <= '0;
            else
                idx_q <= idx_q + 3'd1;
        end
    end

    // Drop the mask into rows 0..1, columns 3..6
    always_comb begin
        spawn_grid = '0;
        for (int r = 0; r < MASK_ROWS; r++) begin
            for (int c = 0; c < MASK_COLS; c++) begin
                spawn_grid[r][SPAWN_COL + c] = SPAWN_MASK[idx_q][r][c];
            end
        end
    end

endmodule

// ==== piece_dropper.sv ====
`timescale 1ns/100ps

module piece_dropper
    import tetris_grid_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  load,                 // Take a fresh piece
    input  logic  step,                 // Move down one row
    input  grid_t spawn_grid,
    input  grid_t stored_grid,          // Locked cells
    output grid_t piece,
    output logic  can_move
);

    grid_t piece_q;                     // Falling piece cells
    grid_t shifted;                     // Piece one row lower
    logic  at_floor;
    logic  blocked;

    // Everything moves one row toward the bottom
    always_comb begin
        shifted[0] = '0;                // Top row empties
        for (int r = 1; r < ROWS; r++) begin
            shifted[r] = piece_q[r-1];
        end
    end

    // Any cell in the last row means it cannot go lower
    assign at_floor = |piece_q[ROWS-1];

    // Collision with the stored board after the move
    assign blocked = |(shifted & stored_grid);

    assign can_move = !at_floor && !blocked;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            piece_q <= '0;
        end else if (load) begin
            piece_q <= spawn_grid;      // New shape at the top
        end else if (step) begin
            piece_q <= shifted;
        end
    end

    // While loading, show the incoming shape so the spawn
    // overlap check sees it in the same cycle
    assign piece = load ? spawn_grid : piece_q;

endmodule

// ==== line_clearer.sv ====
`timescale 1ns/100ps

module line_clearer
    import tetris_grid_pkg::*;
(
    input  grid_t      grid_in,         // Board with the piece merged in
    output grid_t      grid_out,        // Board with full rows removed
    output logic [2:0] cleared          // Number of full rows, 0..4
);

    row_idx_t wr_row;                   // Next free row from the bottom

    // Walk bottom up, copy every non-full row to the lowest free slot.
    // Rows above the last copy stay empty.
    always_comb begin
        grid_out = '0;
        cleared  = '0;
        wr_row   = row_idx_t'(ROWS - 1);
        for (int r = ROWS - 1; r >= 0; r--) begin
            if (&grid_in[r]) begin
                cleared = cleared + 3'd1;   // Full row, dropped
            end else begin
                grid_out[wr_row] = grid_in[r];
                wr_row = wr_row - 5'd1;
            end
        end
    end

endmodule

// ==== tetris_fsm.sv ====
`timescale 1ns/100ps

module tetris_fsm
    import tetris_grid_pkg::*;
    import tetris_piece_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       drop_tick,       // Gravity pulse
    input  logic       frame_ready,     // Renderer accepts
    input  grid_t      piece,           // From dropper
    input  grid_t      cleared_grid,    // From line clearer
    input  logic [2:0] cleared,
    input  logic       can_move,
    output logic       advance,         // Next shape
    output logic       load,            // Capture spawn grid
    output logic       step,            // Shift piece down
    output logic       frame_valid,
    output grid_t      merged_grid,     // Stored plus piece
    output grid_t      stored_grid,
    output frame_t     frame
);

    game_state_t state_q;
    game_state_t state_d;
    grid_t       stored_q;              // Locked cells
    score_t      score_q;               // Lines removed so far
    logic        frame_pend_q;          // Frame waiting for ready
    logic        tick_taken;
    logic        overlap;               // New piece hits stored cells
    logic        raise_frame;

    // Ticks are dropped while the renderer still holds a frame
    assign tick_taken = drop_tick && !frame_pend_q && (state_q == FALLING);

    assign overlap     = |(stored_q & piece);
    assign merged_grid = stored_q | piece;
    assign stored_grid = stored_q;

    // Control pulses, all from the state register
    assign load    = (state_q == SPAWN);
    assign advance = (state_q == CLEAR);
    assign step    = tick_taken && can_move;

    // Spawn always reports, a fall reports after each move
    assign raise_frame = (state_q == SPAWN) || step;

    always_comb begin
        state_d = state_q;
        case (state_q)
            SPAWN:   state_d = overlap ? OVER : FALLING;
            FALLING: begin
                if (tick_taken && !can_move)
                    state_d = LOCK;     // Landed
            end
            LOCK:    state_d = CLEAR;
            CLEAR:   state_d = SPAWN;
            OVER:    state_d = OVER;    // Wait for reset
            default: state_d = SPAWN;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            state_q <= SPAWN;
        else
            state_q <= state_d;
    end

    // Board and score updates
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            stored_q <= '0;
            score_q  <= '0;
        end else if (state_q == LOCK) begin
            stored_q <= merged_grid;            // Freeze the piece
        end else if (state_q == CLEAR) begin
            stored_q <= cleared_grid;           // Full rows gone
            score_q  <= score_q + score_t'(cleared);
        end
    end

    // Pending flag, held until the transfer
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            frame_pend_q <= 1'b0;
        else if (raise_frame)
            frame_pend_q <= 1'b1;
        else if (frame_pend_q && frame_ready)
            frame_pend_q <= 1'b0;
    end

    assign frame_valid = frame_pend_q;

    // Frame built from registers only, so it holds while pending.
    // In OVER the piece is the one that overlapped.
    always_comb begin
        frame.cells     = merged_grid;
        frame.score     = score_q;
        frame.game_over = (state_q == OVER);
    end

endmodule

// ==== tetris_top.sv ====
`timescale 1ns/100ps

module tetris_top
    import tetris_grid_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   drop_tick,
    input  logic   frame_ready,
    output logic   frame_valid,
    output frame_t frame
);

    logic       advance;
    logic       load;
    logic       step;
    logic       can_move;
    logic [2:0] cleared;
    grid_t      spawn_grid;             // Generator to dropper
    grid_t      piece;                  // Falling piece
    grid_t      stored_grid;            // Locked board
    grid_t      merged_grid;            // Board with piece merged
    grid_t      cleared_grid;           // After row removal

    piece_generator i_generator (
        .clk        (clk),
        .reset      (reset),
        .advance    (advance),
        .spawn_grid (spawn_grid)
    );

    piece_dropper i_dropper (
        .clk         (clk),
        .reset       (reset),
        .load        (load),
        .step        (step),
        .spawn_grid  (spawn_grid),
        .stored_grid (stored_grid),
        .piece       (piece),
        .can_move    (can_move)
    );

    line_clearer i_clearer (
        .grid_in  (merged_grid),
        .grid_out (cleared_grid),
        .cleared  (cleared)
    );

    tetris_fsm i_fsm (
        .clk          (clk),
        .reset        (reset),
        .drop_tick    (drop_tick),
        .frame_ready  (frame_ready),
        .piece        (piece),
        .cleared_grid (cleared_grid),
        .cleared      (cleared),
        .can_move     (can_move),
        .advance      (advance),
        .load         (load),
        .step         (step),
        .frame_valid  (frame_valid),
        .merged_grid  (merged_grid),
        .stored_grid  (stored_grid),
        .frame        (frame)
    );

endmodule

// ==== tb_tetris.sv ====
`timescale 1ns/100ps

module tb_tetris
    import tetris_grid_pkg::*;
    import tetris_piece_pkg::*;
();

    logic        clk;
    logic        reset;
    logic        drop_tick;
    logic        frame_ready;
    logic        frame_valid;
    frame_t      frame;

    // Reference model of the playfield
    grid_t       m_stored;              // Locked cells
    grid_t       m_piece;               // Falling piece
    int          m_idx;                 // Current shape
    score_t      m_score;
    logic        m_over;

    frame_t      last_frame;            // Last frame taken from the DUT
    logic [31:0] lcg_state = 32'h71ad;
    int          cycles = 0;

    tetris_top i_dut (
        .clk         (clk),
        .reset       (reset),
        .drop_tick   (drop_tick),
        .frame_ready (frame_ready),
        .frame_valid (frame_valid),
        .frame       (frame)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // About 400 ticks at up to 40 cycles each, plus margin
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= 20000) begin
            $display("timeout: the tests did not finish within %0d clock cycles", cycles);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    end

    task automatic check_value(input logic [255:0] got, input logic [255:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("error at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    endtask

    function automatic logic next_rand_bit();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[16];           // Low bits of an LCG repeat quickly
    endfunction

    // Shape mask placed in rows 0 and 1, columns 3 to 6
    function automatic grid_t spawn_grid_of(input int idx);
        grid_t g;
        g = '0;
        for (int r = 0; r < 2; r++) begin
            g[r][6:3] = SPAWN_MASK[idx][r];
        end
        return g;
    endfunction

    function automatic logic piece_can_fall();
        if (m_piece[ROWS-1] != '0)
            return 1'b0;                // On the floor
        for (int r = 1; r < ROWS; r++) begin
            if ((m_piece[r-1] & m_stored[r]) != '0)
                return 1'b0;            // Cell below already taken
        end
        return 1'b1;
    endfunction

    // Remove one full row at a time and pull everything above down
    function automatic void clear_full_rows();
        int r;
        int n;
        r = ROWS - 1;
        n = 0;
        while (r >= 0) begin
            if (m_stored[r] == {COLS{1'b1}}) begin
                for (int k = r; k > 0; k--) begin
                    m_stored[k] = m_stored[k-1];
                end
                m_stored[0] = '0;
                n++;                    // Same row checked again
            end else begin
                r--;
            end
        end
        m_score = m_score + score_t'(n);
    endfunction

    // One taken tick, returns the cycles until the next frame
    function automatic int model_step();
        if (piece_can_fall()) begin
            for (int r = ROWS - 1; r > 0; r--) begin
                m_piece[r] = m_piece[r-1];
            end
            m_piece[0] = '0;
            return 1;
        end
        m_stored = m_stored | m_piece;  // Lock
        clear_full_rows();
        m_idx   = (m_idx + 1) % NUM_PIECES;
        m_piece = spawn_grid_of(m_idx);
        m_over  = (m_stored & m_piece) != '0;
        return 4;                       // LOCK, CLEAR, SPAWN, raise
    endfunction

    function automatic frame_t expected_frame();
        frame_t f;
        f.cells     = m_stored | m_piece;
        f.score     = m_score;
        f.game_over = m_over;
        return f;
    endfunction

    // Tick pulse, then count cycles until frame_valid
    task automatic send_tick(output int lat);
        drop_tick = 1'b1;
        @(negedge clk);
        drop_tick = 1'b0;
        lat = 1;
        while (!frame_valid) begin
            @(negedge clk);
            lat++;
        end
    endtask

    // Frame must hold while ready is low
    task automatic take_frame(input frame_t exp, input logic rand_ready);
        logic done;
        done = 1'b0;
        last_frame = frame;
        while (!done) begin
            check_value(256'(frame_valid), 256'(1), "frame_valid held until transfer");
            check_value(256'(frame), 256'(exp), "frame contents");
            frame_ready = rand_ready ? next_rand_bit() : 1'b1;
            done = frame_ready;         // Transfer on the coming edge
            @(negedge clk);
        end
        frame_ready = 1'b0;
        check_value(256'(frame_valid), 256'(0), "frame_valid low after transfer");
    endtask

    task automatic run_tick(input logic rand_ready, output int lat);
        int     lat_exp;
        frame_t exp;
        lat_exp = model_step();
        exp     = expected_frame();
        send_tick(lat);
        check_value(256'(lat), 256'(lat_exp), "cycles from tick to frame");
        take_frame(exp, rand_ready);
    endtask

    // Tick until the piece locks and the next one spawns
    task automatic drop_piece(input logic rand_ready);
        int lat;
        lat = 0;
        while (lat != 4) begin
            run_tick(rand_ready, lat);
        end
    endtask

    task automatic check_spawn_rows(input int k);
        for (int r = 0; r < 2; r++) begin
            check_value(256'(last_frame.cells[r]), 256'({SPAWN_MASK[k][r], 3'b000}),
                        $sformatf("spawn row %0d of shape %0d", r, k));
        end
    endtask

    task automatic check_first_frame();
        frame_t exp;
        m_stored = '0;
        m_score  = '0;
        m_over   = 1'b0;
        m_idx    = 0;
        m_piece  = spawn_grid_of(0);
        exp      = expected_frame();
        while (!frame_valid) begin
            @(negedge clk);
        end
        take_frame(exp, 1'b0);
        check_value(256'(last_frame.cells[0]), 256'(10'h000), "row 0 of first I");
        check_value(256'(last_frame.cells[1]), 256'(10'h078), "row 1 of first I");
    endtask

    // I falls from row 1 to row 21, then O spawns
    task automatic fall_and_lock();
        int moves;
        int lat;
        moves = 0;
        lat   = 0;
        while (lat != 4) begin
            run_tick(1'b0, lat);
            if (lat == 1)
                moves++;
        end
        check_value(256'(moves), 256'(20), "rows moved by the first I");
        check_value(256'(last_frame.cells[ROWS-1]), 256'(10'h078), "locked I on bottom row");
        check_value(256'(last_frame.cells[0]), 256'(10'h030), "row 0 of O at spawn");
        check_value(256'(last_frame.cells[1]), 256'(10'h030), "row 1 of O at spawn");
    endtask

    task automatic shape_order();
        check_spawn_rows(1);
        for (int k = 2; k <= 7; k++) begin
            drop_piece(1'b0);
            check_spawn_rows(k % NUM_PIECES);   // T S Z J L, then I again
        end
    endtask

    // Straight drops only fill columns 3 to 6, rows never complete
    task automatic row_clear_score();
        drop_piece(1'b0);
        check_value(256'(last_frame.score), 256'(0), "score with no full row");
        check_value(256'(last_frame.cells[ROWS-1]), 256'(10'h078), "partial bottom row kept");
    endtask

    task automatic stall_holds_frame();
        int     lat;
        int     lat_exp;
        frame_t exp;
        lat_exp = model_step();
        exp     = expected_frame();
        send_tick(lat);
        check_value(256'(lat), 256'(lat_exp), "cycles from tick to frame");
        repeat (3) begin
            check_value(256'(frame_valid), 256'(1), "frame_valid during stall");
            check_value(256'(frame), 256'(exp), "frame during stall");
            @(negedge clk);
        end
        drop_tick = 1'b1;               // Must be ignored, frame pending
        @(negedge clk);
        drop_tick = 1'b0;
        take_frame(exp, 1'b0);
        repeat (4) begin
            check_value(256'(frame_valid), 256'(0), "no frame from ignored tick");
            @(negedge clk);
        end
        drop_piece(1'b1);
    endtask

    task automatic run_to_game_over();
        while (!m_over) begin
            drop_piece(1'b1);
        end
        repeat (3) begin
            drop_tick = 1'b1;
            @(negedge clk);
            drop_tick = 1'b0;
            repeat (10) begin
                check_value(256'(frame_valid), 256'(0), "no frame after game over");
                check_value(256'(frame.game_over), 256'(1), "game_over held after transfer");
                @(negedge clk);
            end
        end
    endtask

    initial begin
        reset       = 1'b1;
        drop_tick   = 1'b0;
        frame_ready = 1'b0;
        repeat (8) @(negedge clk);
        reset = 1'b0;

        check_first_frame();
        fall_and_lock();
        shape_order();
        row_clear_score();
        stall_holds_frame();
        run_to_game_over();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== verilog.f ====
tetris_grid_pkg.sv
tetris_piece_pkg.sv
piece_generator.sv
piece_dropper.sv
line_clearer.sv
tetris_fsm.sv
tetris_top.sv
tb_tetris.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module tb_tetris -o tb_tetris

# The simulator may exit non-zero on failure, the log decides
./obj_dir/tb_tetris > sim.log 2>&1 || true
cat sim.log

if grep -q "^STATUS: PASS$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
